/* Makefile */
# Verilator simulation of the signal generator core
# Override on the command line, for example make sim BUILD_DIR=obj

VERILATOR ?= verilator
TOP       ?= signal_gen_tb
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert -j 0

# Exit status of the simulation binary is the test result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f sources.f
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

.PHONY: sim clean

/* sources.f */
src/signal_gen_pkg.sv
src/dac_ctrl_sync.sv
src/pulse_timer.sv
src/dds_iq_core.sv
src/triangle_wave_gen.sv
src/signal_gen_top.sv
tb/tb_clock_gen.sv
tb/signal_gen_properties.sv
tb/signal_gen_tb.sv

/* src/dac_ctrl_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module dac_ctrl_sync import signal_gen_pkg::*;
(
  input  wire logic     clk_user_bufg,
  input  wire logic     rst_glb,
  input  wire logic     dds_reset,
  input  wire dac_fsc_t fsc_req,
  output logic          dds_rst_sync,
  output dac_fsc_t      fsc
);

  logic rst_dds_d1;

  // Zero request means maximum current
  function automatic fsc_t fsc_fix(input fsc_t code);
    return (code == '0) ? fsc_t'(FSC_MAX) : code;
  endfunction

  always_ff @(posedge clk_user_bufg or posedge rst_glb)
  begin
    if (rst_glb)
    begin
      rst_dds_d1   <= 1'b1;           // DDS held in reset until released
      dds_rst_sync <= 1'b1;
    end
    else
    begin
      rst_dds_d1   <= dds_reset;
      dds_rst_sync <= rst_dds_d1;
    end
  end

  always_ff @(posedge clk_user_bufg or posedge rst_glb)
  begin
    if (rst_glb)
    begin
      fsc.dds_fsc <= fsc_t'(FSC_MAX);
      fsc.vc1_fsc <= fsc_t'(FSC_MAX);
      fsc.vc2_fsc <= fsc_t'(FSC_MAX);
    end
    else
    begin
      fsc.dds_fsc <= fsc_fix(fsc_req.dds_fsc);
      fsc.vc1_fsc <= fsc_fix(fsc_req.vc1_fsc);
      fsc.vc2_fsc <= fsc_fix(fsc_req.vc2_fsc);
    end
  end

endmodule

`default_nettype wire

/* src/dds_iq_core.sv */
`timescale 1ns/1ps
`default_nettype none

module dds_iq_core import signal_gen_pkg::*;
(
  input  wire logic     clk_user_bufg,
  input  wire logic     rst_glb,
  input  wire logic     dds_rst_sync,
  input  wire dds_cfg_t cfg,
  input  wire logic     pulse_gate,
  output iq_sample_t    iq
);

  localparam int LUT_DEPTH = 1 << LUT_ADDR_W;

  sample_t                 lut [LUT_DEPTH];
  phase_t                  phase;
  logic [1:0]              quad_sin;
  logic [1:0]              quad_cos;
  logic [LUT_ADDR_W-1:0]   idx;
  sample_t                 sin_val;
  sample_t                 cos_val;
  sample_t                 s1_sin;
  sample_t                 s1_cos;
  logic                    s1_gate;
  logic signed [15:0]      amp_s;
  logic signed [31:0]      sin_prod;
  logic signed [31:0]      cos_prod;
  logic                    mute;

  // Constant quarter table
  for (genvar k = 0; k < LUT_DEPTH; k++)
  begin : g_lut
    assign lut[k] = sine_quarter(k);
  end

  // Odd quadrants read the table backwards, upper half is negated
  function automatic sample_t quad_lookup(input logic [1:0] quad,
                                          input logic [LUT_ADDR_W-1:0] addr);
    sample_t mag;
    mag = quad[0] ? lut[~addr] : lut[addr];
    return quad[1] ? -mag : mag;
  endfunction

  assign quad_sin = phase[PHASE_W-1 -: 2];
  assign quad_cos = quad_sin + 2'd1;    // Cosine leads by a quarter turn
  assign idx      = phase[PHASE_W-3 -: LUT_ADDR_W];
  assign sin_val  = quad_lookup(quad_sin, idx);
  assign cos_val  = quad_lookup(quad_cos, idx);

  assign amp_s    = {1'b0, cfg.amp};
  assign sin_prod = s1_sin * amp_s;
  assign cos_prod = s1_cos * amp_s;
  assign mute     = (cfg.mode == MODE_PULSE) && !s1_gate;

  // Phase accumulator
  always_ff @(posedge clk_user_bufg or posedge rst_glb)
  begin
    if (rst_glb)
      phase <= '0;
    else if (dds_rst_sync)
      phase <= '0;
    else
      phase <= phase + cfg.fcw;
  end

  // Stage 1, table lookup
  always_ff @(posedge clk_user_bufg or posedge rst_glb)
  begin
    if (rst_glb)
    begin
      s1_sin  <= '0;
      s1_cos  <= '0;
      s1_gate <= 1'b0;
    end
    else if (dds_rst_sync)
    begin
      s1_sin  <= '0;
      s1_cos  <= '0;
      s1_gate <= 1'b0;
    end
    else
    begin
      s1_sin  <= sin_val;
      s1_cos  <= cos_val;
      s1_gate <= pulse_gate;
    end
  end

  // Stage 2, amplitude scaling and pulse blanking
  always_ff @(posedge clk_user_bufg or posedge rst_glb)
  begin
    if (rst_glb)
      iq <= '0;
    else if (dds_rst_sync || mute)
      iq <= '0;
    else
    begin
      iq.i <= sample_t'(sin_prod >>> AMP_SHIFT);
      iq.q <= sample_t'(cos_prod >>> AMP_SHIFT);
    end
  end

endmodule

`default_nettype wire

/* src/pulse_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module pulse_timer import signal_gen_pkg::*;
(
  input  wire logic clk_user_bufg,
  input  wire logic rst_glb,
  input  wire logic dds_rst_sync,
  input  wire prt_t prt_width,
  input  wire prt_t prt_cycle,
  output logic      pulse_gate
);

  prt_t count;
  prt_t count_last;
  prt_t count_nxt;

  // Period of zero behaves as one
  assign count_last = (prt_cycle == '0) ? '0 : prt_cycle - 1'b1;
  assign count_nxt  = (count >= count_last) ? '0 : count + 1'b1;

  always_ff @(posedge clk_user_bufg or posedge rst_glb)
  begin
    if (rst_glb)
    begin
      count      <= '0;
      pulse_gate <= 1'b0;
    end
    else if (dds_rst_sync)
    begin
      count      <= '0;
      pulse_gate <= 1'b0;
    end
    else
    begin
      count      <= count_nxt;
      pulse_gate <= (count_nxt < prt_width); // Gate tracks the new count
    end
  end

endmodule

`default_nettype wire

/* src/signal_gen_pkg.sv */
`default_nettype none

package signal_gen_pkg;

  localparam int PHASE_W    = 32;
  localparam int SAMPLE_W   = 16;
  localparam int AMP_SHIFT  = 15;
  localparam int LUT_ADDR_W = 6;
  localparam int FSC_MAX    = 1023;

  typedef logic        [PHASE_W-1:0]  phase_t;
  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic        [15:0]         vc_word_t;
  typedef logic        [14:0]         amp_t;
  typedef logic        [9:0]          fsc_t;
  typedef logic        [31:0]         prt_t;

  typedef enum logic {
    MODE_CW    = 1'b0,
    MODE_PULSE = 1'b1
  } dds_mode_t;

  typedef struct packed {
    dds_mode_t mode;
    phase_t    fcw;                 // Tone frequency word
    amp_t      amp;                 // Linear gain, 32767 is full scale
    prt_t      prt_width;           // Gate high time in cycles
    prt_t      prt_cycle;           // Pulse period in cycles
  } dds_cfg_t;

  typedef struct packed {
    phase_t   vc_fcw;
    vc_word_t vc_amp;
    vc_word_t vc_offset;
  } vc_cfg_t;

  typedef struct packed {
    fsc_t dds_fsc;
    fsc_t vc1_fsc;
    fsc_t vc2_fsc;
  } dac_fsc_t;

  typedef struct packed {
    sample_t i;
    sample_t q;
  } iq_sample_t;

  // Quarter-wave entry k, evaluated at elaboration with a Q30 Taylor series
  function automatic sample_t sine_quarter(input int k);
    longint x;
    longint x2;
    longint term;
    longint sum;
    x    = (64'sd3373259426 * longint'(2 * k + 1)) >>> 8; // Pi * (2k+1) / 256
    x2   = (x * x) >>> 30;
    term = x;
    sum  = x;
    for (int n = 1; n < 10; n++)
    begin
      term = -((term * x2) >>> 30) / longint'((2 * n) * (2 * n + 1));
      sum  = sum + term;
    end
    return sample_t'((sum * 32767 + (64'sd1 <<< 29)) >>> 30); // Round to nearest
  endfunction

endpackage

`default_nettype wire

/* src/signal_gen_top.sv */
`timescale 1ns/1ps
`default_nettype none

module signal_gen_top import signal_gen_pkg::*;
(
  input  wire logic     clk_user_bufg,
  input  wire logic     rst_glb,
  input  wire logic     dds_reset,
  input  wire dds_cfg_t dds_cfg,
  input  wire vc_cfg_t  vc_cfg,
  input  wire dac_fsc_t fsc_req,
  output iq_sample_t    iq,
  output dac_fsc_t      fsc,
  output vc_word_t      vc_triangle,
  output vc_word_t      vc_dac_data
);

  logic dds_rst_sync;
  logic pulse_gate;

  dac_ctrl_sync dac_ctrl_sync_inst (
    .clk_user_bufg (clk_user_bufg),
    .rst_glb       (rst_glb),
    .dds_reset     (dds_reset),
    .fsc_req       (fsc_req),
    .dds_rst_sync  (dds_rst_sync),
    .fsc           (fsc)
  );

  pulse_timer pulse_timer_inst (
    .clk_user_bufg (clk_user_bufg),
    .rst_glb       (rst_glb),
    .dds_rst_sync  (dds_rst_sync),
    .prt_width     (dds_cfg.prt_width),
    .prt_cycle     (dds_cfg.prt_cycle),
    .pulse_gate    (pulse_gate)
  );

  dds_iq_core dds_iq_core_inst (
    .clk_user_bufg (clk_user_bufg),
    .rst_glb       (rst_glb),
    .dds_rst_sync  (dds_rst_sync),
    .cfg           (dds_cfg),
    .pulse_gate    (pulse_gate),
    .iq            (iq)
  );

  // Voltage-control DAC path, free running after global reset
  triangle_wave_gen triangle_wave_gen_inst (
    .clk_user_bufg (clk_user_bufg),
    .rst_glb       (rst_glb),
    .vc_cfg        (vc_cfg),
    .vc_triangle   (vc_triangle),
    .vc_dac_data   (vc_dac_data)
  );

endmodule

`default_nettype wire

/* src/triangle_wave_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module triangle_wave_gen import signal_gen_pkg::*;
(
  input  wire logic    clk_user_bufg,
  input  wire logic    rst_glb,
  input  wire vc_cfg_t vc_cfg,
  output vc_word_t     vc_triangle,
  output vc_word_t     vc_dac_data
);

  phase_t      phase;
  vc_word_t    ramp;
  vc_word_t    fold;
  logic [31:0] tri_prod;
  vc_word_t    tri_val;
  logic [16:0] dc_sum;

  assign ramp     = phase[30:15];
  assign fold     = phase[31] ? 16'hffff - ramp : ramp; // Falling half mirrors
  assign tri_prod = fold * vc_cfg.vc_amp;
  assign tri_val  = tri_prod[31:16];
  assign dc_sum   = {1'b0, tri_val} + {1'b0, vc_cfg.vc_offset};

  always_ff @(posedge clk_user_bufg or posedge rst_glb)
  begin
    if (rst_glb)
      phase <= '0;
    else
      phase <= phase + vc_cfg.vc_fcw;
  end

  always_ff @(posedge clk_user_bufg or posedge rst_glb)
  begin
    if (rst_glb)
    begin
      vc_triangle <= '0;
      vc_dac_data <= '0;
    end
    else
    begin
      vc_triangle <= tri_val;
      vc_dac_data <= dc_sum[16] ? 16'hffff : dc_sum[15:0]; // Clip at full scale
    end
  end

endmodule

`default_nettype wire

/* tb/signal_gen_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module signal_gen_properties import signal_gen_pkg::*;
(
  input wire logic       clk_user_bufg,
  input wire logic       rst_glb,
  input wire logic       dds_rst_sync,
  input wire iq_sample_t iq,
  input wire dac_fsc_t   fsc,
  input wire vc_word_t   vc_triangle,
  input wire vc_word_t   vc_dac_data
);

  fsc_never_zero: assert property (
    @(posedge clk_user_bufg) disable iff (rst_glb)
    (fsc.dds_fsc != '0) && (fsc.vc1_fsc != '0) && (fsc.vc2_fsc != '0))
    else $error("Full-scale code field at zero");

  // Stage 2 clears on the edge after the rise, stage 1 output is zero one edge later
  iq_quiet_after_reset: assert property (
    @(posedge clk_user_bufg) disable iff (rst_glb)
    $rose(dds_rst_sync) |=> (iq == '0) ##1 (iq == '0))
    else $error("IQ not zero after soft reset");

  dc_offset_not_below: assert property (
    @(posedge clk_user_bufg) disable iff (rst_glb)
    vc_dac_data >= vc_triangle)
    else $error("VC DAC word below triangle value");

endmodule

bind signal_gen_top signal_gen_properties signal_gen_properties_inst (
  .clk_user_bufg (clk_user_bufg),
  .rst_glb       (rst_glb),
  .dds_rst_sync  (dds_rst_sync),
  .iq            (iq),
  .fsc           (fsc),
  .vc_triangle   (vc_triangle),
  .vc_dac_data   (vc_dac_data)
);

`default_nettype wire

/* tb/signal_gen_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module signal_gen_tb import signal_gen_pkg::*;
();

  localparam int  RESET_CYCLES   = 16;
  localparam int  TIMEOUT_CYCLES = 4000; // Scripted run is about 1800 cycles
  localparam real PI             = 3.14159265358979;

  logic       clk_user_bufg;
  logic       rst_glb;
  logic       dds_reset;
  dds_cfg_t   dds_cfg;
  vc_cfg_t    vc_cfg;
  dac_fsc_t   fsc_req;
  iq_sample_t iq;
  dac_fsc_t   fsc;
  vc_word_t   vc_triangle;
  vc_word_t   vc_dac_data;

  logic [31:0] lfsr_state  = 32'hd0c3;
  string       test_name   = "reset";
  int          cycle_count = 0;
  int          sat_count   = 0;

  // Model state
  logic       m_rst_d1;
  logic       m_rst_sync;
  dac_fsc_t   m_fsc;
  prt_t       m_count;
  logic       m_gate;
  phase_t     m_phase;
  int         m_s1_sin;
  int         m_s1_cos;
  logic       m_s1_gate;
  iq_sample_t m_iq;
  phase_t     m_vc_phase;
  vc_word_t   m_vc_tri;
  vc_word_t   m_vc_dac;

  tb_clock_gen tb_clock_gen_inst (
    .clk_user_bufg (clk_user_bufg)
  );

  signal_gen_top signal_gen_top_inst (
    .clk_user_bufg (clk_user_bufg),
    .rst_glb       (rst_glb),
    .dds_reset     (dds_reset),
    .dds_cfg       (dds_cfg),
    .vc_cfg        (vc_cfg),
    .fsc_req       (fsc_req),
    .iq            (iq),
    .fsc           (fsc),
    .vc_triangle   (vc_triangle),
    .vc_dac_data   (vc_dac_data)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic int ref_quarter(input int k);
    return $rtoi(32767.0 * $sin(PI / 2.0 * (real'(k) + 0.5) / 64.0) + 0.5);
  endfunction

  // Sine of the phase, or cosine with a quarter shift of one
  function automatic int ref_sample(input phase_t p, input int quarter_shift);
    int quad;
    int idx;
    int mag;
    quad = (int'(p[31:30]) + quarter_shift) % 4;
    idx  = int'(p[29:24]);
    mag  = (quad % 2 == 1) ? ref_quarter(63 - idx) : ref_quarter(idx);
    return (quad >= 2) ? -mag : mag;
  endfunction

  function automatic sample_t ref_scale(input int s, input amp_t amp);
    longint prod;
    prod = longint'(s) * longint'(amp);
    return sample_t'(prod >>> 15);
  endfunction

  function automatic vc_word_t ref_triangle(input phase_t p, input vc_word_t amp);
    vc_word_t    u;
    vc_word_t    fold;
    logic [31:0] prod;
    u    = p[30:15];
    fold = p[31] ? 16'd65535 - u : u;
    prod = {16'd0, fold} * {16'd0, amp};
    return prod[31:16];
  endfunction

  function automatic vc_word_t ref_offset(input vc_word_t t, input vc_word_t off);
    int s;
    s = int'(t) + int'(off);
    return (s > 65535) ? 16'hffff : vc_word_t'(s);
  endfunction

  function automatic fsc_t fsc_expect(input fsc_t r);
    return (r == 10'd0) ? 10'd1023 : r;
  endfunction

  function automatic prt_t next_count(input prt_t c, input prt_t cycle);
    prt_t period;
    prt_t nxt;
    period = (cycle == 32'd0) ? 32'd1 : cycle;
    nxt    = c + 32'd1;
    return (nxt >= period) ? 32'd0 : nxt;
  endfunction

  always @(posedge clk_user_bufg or posedge rst_glb)
  begin
    prt_t cnt_next;
    if (rst_glb)
    begin
      m_rst_d1   <= 1'b1;
      m_rst_sync <= 1'b1;
      m_fsc      <= {10'd1023, 10'd1023, 10'd1023};
      m_count    <= '0;
      m_gate     <= 1'b0;
      m_phase    <= '0;
      m_s1_sin   <= 0;
      m_s1_cos   <= 0;
      m_s1_gate  <= 1'b0;
      m_iq       <= '0;
      m_vc_phase <= '0;
      m_vc_tri   <= '0;
      m_vc_dac   <= '0;
    end
    else
    begin
      m_rst_d1      <= dds_reset;
      m_rst_sync    <= m_rst_d1;
      m_fsc.dds_fsc <= fsc_expect(fsc_req.dds_fsc);
      m_fsc.vc1_fsc <= fsc_expect(fsc_req.vc1_fsc);
      m_fsc.vc2_fsc <= fsc_expect(fsc_req.vc2_fsc);
      if (m_rst_sync)
      begin
        m_count   <= '0;
        m_gate    <= 1'b0;
        m_phase   <= '0;
        m_s1_sin  <= 0;
        m_s1_cos  <= 0;
        m_s1_gate <= 1'b0;
        m_iq      <= '0;
      end
      else
      begin
        cnt_next = next_count(m_count, dds_cfg.prt_cycle);
        m_count   <= cnt_next;
        m_gate    <= (cnt_next < dds_cfg.prt_width);
        m_phase   <= m_phase + dds_cfg.fcw;
        m_s1_sin  <= ref_sample(m_phase, 0);
        m_s1_cos  <= ref_sample(m_phase, 1);
        m_s1_gate <= m_gate;
        if ((dds_cfg.mode == MODE_PULSE) && !m_s1_gate)
          m_iq <= '0;                                     // Blanked outside the pulse
        else
        begin
          m_iq.i <= ref_scale(m_s1_sin, dds_cfg.amp);
          m_iq.q <= ref_scale(m_s1_cos, dds_cfg.amp);
        end
      end
      m_vc_tri   <= ref_triangle(m_vc_phase, vc_cfg.vc_amp);
      m_vc_dac   <= ref_offset(ref_triangle(m_vc_phase, vc_cfg.vc_amp), vc_cfg.vc_offset);
      m_vc_phase <= m_vc_phase + vc_cfg.vc_fcw;
    end
  end

  task automatic check(input string what, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual)
    begin
      $display("[FAIL] %s: %s expected 0x%0h actual 0x%0h",
               test_name, what, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1, "Value mismatch");
    end
  endtask

  // Outputs are registered, so the falling edge sees settled values
  always @(negedge clk_user_bufg)
  begin
    if (!rst_glb)
    begin
      check("iq", 64'(m_iq), 64'(iq));
      check("fsc", 64'(m_fsc), 64'(fsc));
      check("vc_triangle", 64'(m_vc_tri), 64'(vc_triangle));
      check("vc_dac_data", 64'(m_vc_dac), 64'(vc_dac_data));
      if (test_name == "triangle" && vc_dac_data == 16'hffff)
        sat_count++;
    end
  end

  always @(posedge clk_user_bufg)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run still going after %0d cycles in %s", cycle_count, test_name);
      $display("*** TEST FAILED ***");
      $fatal(1, "Timeout");
    end
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_user_bufg);
  endtask

  function automatic fsc_t random_fsc();
    logic [31:0] r;
    r = rand_bits(12);
    return (r[11:10] == 2'd0) ? 10'd0 : r[9:0];           // About a quarter are zero
  endfunction

  task automatic run_fsc_test();
    test_name = "fsc";
    fsc_req   = '0;
    wait_cycles(1);
    for (int n = 0; n < 40; n++)
    begin
      fsc_req.dds_fsc = random_fsc();
      fsc_req.vc1_fsc = random_fsc();
      fsc_req.vc2_fsc = random_fsc();
      wait_cycles(1);
    end
  endtask

  // Soft reset, new tone settings, then release
  task automatic start_tone(input dds_mode_t mode, input phase_t fcw, input amp_t amp);
    dds_reset    = 1'b1;
    dds_cfg.mode = mode;
    dds_cfg.fcw  = fcw;
    dds_cfg.amp  = amp;
    wait_cycles(4);
    dds_reset = 1'b0;
  endtask

  task automatic run_cw_test();
    test_name = "cw";
    for (int t = 0; t < 4; t++)
    begin
      start_tone(MODE_CW, phase_t'(rand_bits(32)), amp_t'(rand_bits(15)));
      wait_cycles(200);
    end
  endtask

  task automatic run_pulse_test();
    test_name         = "pulse";
    dds_cfg.prt_width = 32'd7;
    dds_cfg.prt_cycle = 32'd20;
    start_tone(MODE_PULSE, phase_t'(rand_bits(32)), {1'b1, 14'(rand_bits(14))});
    wait_cycles(200);
  endtask

  task automatic run_amp_test();
    test_name = "amp_zero";
    start_tone(MODE_CW, phase_t'(rand_bits(32)), 15'd0);
    wait_cycles(2);
    for (int n = 0; n < 100; n++)
    begin
      wait_cycles(1);
      check("iq at zero gain", 64'd0, 64'(iq));
    end
    test_name   = "amp_full";
    dds_cfg.amp = 15'h7fff;
    wait_cycles(100);
  endtask

  task automatic run_triangle_test();
    test_name = "triangle";
    sat_count = 0;
    for (int t = 0; t < 6; t++)
    begin
      vc_cfg.vc_fcw    = phase_t'(rand_bits(28));
      vc_cfg.vc_amp    = vc_word_t'(rand_bits(16));
      vc_cfg.vc_offset = vc_word_t'(rand_bits(16));
      if (t == 5)
      begin
        vc_cfg.vc_amp    = 16'hffff;                      // Peaks must clip
        vc_cfg.vc_offset = 16'hc000;
      end
      wait_cycles(60);
    end
    check("saturation seen", 64'd1, 64'(sat_count > 0));
  endtask

  task automatic run_soft_reset_test();
    phase_t fcw;
    amp_t   amp;
    test_name = "soft_reset";
    fcw       = phase_t'(rand_bits(32));
    amp       = {1'b1, 14'(rand_bits(14))};
    start_tone(MODE_CW, fcw, amp);
    wait_cycles(50);
    dds_reset = 1'b1;
    wait_cycles(2);
    for (int n = 0; n < 6; n++)
    begin
      wait_cycles(1);
      check("iq during soft reset", 64'd0, 64'(iq));
    end
    dds_reset = 1'b0;
    wait_cycles(3);
    check("iq before restart", 64'd0, 64'(iq));
    wait_cycles(1);
    check("restart i at phase 0", 64'(ref_scale(ref_sample('0, 0), amp)), 64'(iq.i));
    check("restart q at phase 0", 64'(ref_scale(ref_sample('0, 1), amp)), 64'(iq.q));
    wait_cycles(1);
    check("first i after restart", 64'(ref_scale(ref_sample(fcw, 0), amp)), 64'(iq.i));
    wait_cycles(100);
  endtask

  initial
  begin
    rst_glb           = 1'b1;
    dds_reset         = 1'b1;
    dds_cfg           = '0;
    dds_cfg.prt_cycle = 32'd1;
    vc_cfg            = '0;
    fsc_req           = '0;
    wait_cycles(RESET_CYCLES);
    rst_glb = 1'b0;
    run_fsc_test();
    run_cw_test();
    run_pulse_test();
    run_amp_test();
    run_triangle_test();
    run_soft_reset_test();
    wait_cycles(1);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
(
  output logic clk_user_bufg
);

  localparam realtime HALF_PERIOD = 2.0ns; // 4 ns period

  initial
  begin
    clk_user_bufg = 1'b0;
    forever
      #(HALF_PERIOD) clk_user_bufg = ~clk_user_bufg;
  end

endmodule

`default_nettype wire
